// ==== verilog/mips_pkg.sv ====
/*
  Shared definitions for the single-cycle MIPS core.
  Opcode and function codes, memory sizes, the instruction word views,
  the per-instruction control word and the data bus.
*/

package mips_pkg;
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti  = 6'h0a;
	localparam logic [5:0] op_sltiu = 6'h0b;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_sra  = 6'h03;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_add  = 6'h20;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_sub  = 6'h22;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_nor  = 6'h27;
	localparam logic [5:0] fn_slt  = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	localparam int imem_words = 256;
	localparam int dmem_words = 256;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_t;

	typedef enum logic [1:0] {imm_sign, imm_zero, imm_upper} imm_kind_t;
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_src_t;
	typedef enum logic [2:0] {pc_next, pc_beq, pc_bne, pc_jump, pc_reg} pc_src_t;

	typedef struct packed {
		logic [5:0] alu_funct;
		logic use_imm;
		imm_kind_t imm_kind;
		logic use_shamt;
		logic [4:0] dest;
		logic reg_write;
		logic mem_write;
		wb_src_t wb_src;
		pc_src_t pc_src;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic write;
	} dbus_t;
endpackage

// ==== verilog/alu.sv ====
/*
  Combinational ALU for the MIPS integer subset.
  Add, subtract, logic, set-less-than and shifts, with zero and
  signed overflow flags.
*/

module alu import mips_pkg::*; (
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [5:0] funct,
	input logic [4:0] shamt,
	output logic [31:0] result,
	output logic zero,
	output logic overflow
);
	logic [31:0] sum;
	logic [31:0] diff;
	logic add_ovf;
	logic sub_ovf;

	assign sum = a + b;
	assign diff = a - b;
	assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]); // Same signs in, other sign out
	assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

	always_comb begin
		result = 32'd0;
		overflow = 1'b0;
		case (funct)
			fn_sll: result = b << shamt;
			fn_srl: result = b >> shamt;
			fn_sra: result = $signed(b) >>> shamt;
			fn_add: begin
				result = sum;
				overflow = add_ovf;
			end
			fn_addu: result = sum;
			fn_sub: begin
				result = diff;
				overflow = sub_ovf;
			end
			fn_subu: result = diff;
			fn_and: result = a & b;
			fn_or: result = a | b;
			fn_xor: result = a ^ b;
			fn_nor: result = ~(a | b);
			fn_slt: result = {31'd0, $signed(a) < $signed(b)};
			fn_sltu: result = {31'd0, a < b};
			default: result = 32'd0; // jr and unknown codes give nothing
		endcase
	end

	assign zero = (result == 32'd0);
endmodule

// ==== verilog/register_file.sv ====
/*
  Thirty-two word register file.
  Two asynchronous read ports, one synchronous write port,
  register zero hard-wired to zero.
*/

module register_file (
	input logic clk,
	input logic [4:0] raddr1,
	input logic [4:0] raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input logic [4:0] waddr,
	input logic [31:0] wdata,
	input logic write
);
	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (write && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

	// Register zero must stay zero even right after a write aimed at it
	zero_reg_reads_zero: assert property (
		@(posedge clk) write && (waddr == 5'd0)
			|=> ((raddr1 != 5'd0) || (rdata1 == 32'd0))
			&& ((raddr2 != 5'd0) || (rdata2 == 32'd0))
	) else $error("register zero read back non-zero");
endmodule

// ==== verilog/instr_decoder.sv ====
/*
  Instruction decoder.
  Maps an instruction word onto the control word that steers the
  register file, the ALU, the data bus and the next-pc choice.
*/

module instr_decoder import mips_pkg::*; (
	input instr_t instr,
	output ctrl_t ctrl
);
	logic is_shift;

	assign is_shift = (instr.r_fields.funct == fn_sll) || (instr.r_fields.funct == fn_srl)
		|| (instr.r_fields.funct == fn_sra);

	always_comb begin
		ctrl = '0; // No write, pc plus four
		ctrl.dest = instr.i_fields.rt;
		case (instr.r_fields.opcode)
			op_rtype: begin
				ctrl.alu_funct = instr.r_fields.funct;
				ctrl.dest = instr.r_fields.rd;
				ctrl.use_shamt = is_shift;
				if (instr.r_fields.funct == fn_jr) begin
					ctrl.pc_src = pc_reg;
				end else begin
					ctrl.reg_write = 1'b1;
				end
			end
			op_addi, op_addiu, op_andi, op_ori, op_slti, op_sltiu, op_lui: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				case (instr.r_fields.opcode)
					op_addi: ctrl.alu_funct = fn_add;
					op_addiu: ctrl.alu_funct = fn_addu;
					op_andi: begin
						ctrl.alu_funct = fn_and;
						ctrl.imm_kind = imm_zero;
					end
					op_ori: begin
						ctrl.alu_funct = fn_or;
						ctrl.imm_kind = imm_zero;
					end
					op_slti: ctrl.alu_funct = fn_slt;
					op_sltiu: ctrl.alu_funct = fn_sltu; // Sign extended, then compared unsigned
					default: begin
						ctrl.alu_funct = fn_addu; // lui adds the shifted value to rs
						ctrl.imm_kind = imm_upper;
					end
				endcase
			end
			op_lw: begin
				ctrl.alu_funct = fn_addu;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src = wb_mem;
			end
			op_sw: begin
				ctrl.alu_funct = fn_addu;
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			op_beq: begin
				ctrl.alu_funct = fn_sub; // Zero flag tells rs equals rt
				ctrl.pc_src = pc_beq;
			end
			op_bne: begin
				ctrl.alu_funct = fn_sub;
				ctrl.pc_src = pc_bne;
			end
			op_j: ctrl.pc_src = pc_jump;
			op_jal: begin
				ctrl.pc_src = pc_jump;
				ctrl.dest = 5'd31;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src = wb_link;
			end
			default: ctrl.dest = 5'd0;
		endcase
	end

	always_comb begin
		assert (!(ctrl.mem_write && ctrl.reg_write))
			else $error("store and register write decoded together");
	end
endmodule

// ==== verilog/cpu.sv ====
/*
  Single-cycle MIPS core.
  Program counter and next-pc choice, immediate extension, operand and
  write-back selection, and the instruction and data bus outputs.
*/

module cpu import mips_pkg::*; (
	input logic clk,
	input logic rst,
	output logic [31:0] iaddr,
	input instr_t iword,
	output dbus_t dbus,
	input logic [31:0] rdata
);
	ctrl_t ctrl;
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] next_pc;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] ext_imm;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic [31:0] wb_data;
	logic [4:0] alu_shamt;
	logic alu_zero;

	instr_decoder decoder (.instr(iword), .ctrl(ctrl));

	register_file regs (
		.clk(clk),
		.raddr1(iword.r_fields.rs),
		.raddr2(iword.r_fields.rt),
		.rdata1(rs_data),
		.rdata2(rt_data),
		.waddr(ctrl.dest),
		.wdata(wb_data),
		.write(ctrl.reg_write && !rst)
	);

	always_comb begin
		case (ctrl.imm_kind)
			imm_zero: ext_imm = {16'd0, iword.i_fields.imm};
			imm_upper: ext_imm = {iword.i_fields.imm, 16'd0};
			default: ext_imm = {{16{iword.i_fields.imm[15]}}, iword.i_fields.imm};
		endcase
	end

	assign alu_b = ctrl.use_imm ? ext_imm : rt_data;
	assign alu_shamt = ctrl.use_shamt ? iword.r_fields.shamt : 5'd0;

	alu alu_unit (
		.a(rs_data),
		.b(alu_b),
		.funct(ctrl.alu_funct),
		.shamt(alu_shamt),
		.result(alu_result),
		.zero(alu_zero),
		.overflow() // No exceptions in this core
	);

	always_comb begin
		case (ctrl.wb_src)
			wb_mem: wb_data = rdata;
			wb_link: wb_data = pc_plus4;
			default: wb_data = alu_result;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + {{14{iword.i_fields.imm[15]}}, iword.i_fields.imm, 2'b00}; // Relative to the branch itself
	assign jump_target = {pc[31:28], iword[25:0], 2'b00};

	always_comb begin
		case (ctrl.pc_src)
			pc_beq: next_pc = alu_zero ? branch_target : pc_plus4;
			pc_bne: next_pc = alu_zero ? pc_plus4 : branch_target;
			pc_jump: next_pc = jump_target;
			pc_reg: next_pc = rs_data;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= 32'd0;
		end else begin
			pc <= next_pc;
		end
	end

	assign iaddr = pc;
	assign dbus.addr = alu_result;
	assign dbus.wdata = rt_data;
	assign dbus.write = ctrl.mem_write && !rst;

	pc_word_aligned: assert property (
		@(posedge clk) disable iff (rst) pc[1:0] == 2'b00
	) else $error("pc is not word aligned");
endmodule

// ==== verilog/mips_system.sv ====
/*
  MIPS subsystem top level.
  The core with its instruction ROM and word-addressed data RAM.
*/

module mips_system import mips_pkg::*; (
	input logic clk,
	input logic rst,
	output logic [31:0] pc,
	output dbus_t dbus
);
	logic [31:0] imem [imem_words];
	logic [31:0] dmem [dmem_words];
	logic [31:0] iaddr;
	instr_t iword;
	logic [31:0] rdata;
	logic [$clog2(imem_words)-1:0] iindex;
	logic [$clog2(dmem_words)-1:0] dindex;

	initial begin
		$readmemh("tb/program.hex", imem);
	end

	cpu core (
		.clk(clk),
		.rst(rst),
		.iaddr(iaddr),
		.iword(iword),
		.dbus(dbus),
		.rdata(rdata)
	);

	// Byte addresses wrap around the memory size
	assign iindex = iaddr[$clog2(imem_words)+1:2];
	assign dindex = dbus.addr[$clog2(dmem_words)+1:2];

	assign iword = imem[iindex];
	assign rdata = dmem[dindex];

	always_ff @(posedge clk) begin
		if (dbus.write) begin
			dmem[dindex] <= dbus.wdata;
		end
	end

	assign pc = iaddr;
endmodule

// ==== tb/mips_system_tb.sv ====
/*
  Testbench for the MIPS subsystem.
  Clock, reset, watchdog, the list of expected stores and the
  assertions that check the data bus and the end of the program.
*/

module mips_system_tb import mips_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period = 10;
	localparam int reset_cycles = 8;
	localparam int max_cycles = 2000; // The program ends in well under a hundred cycles
	localparam int n_stores = 19;
	localparam logic [31:0] store_base = 32'h100;
	localparam logic [31:0] jal_addr = 32'ha8;
	localparam logic [31:0] first_store_pc = 32'h10; // Address of the program's first sw

	// Constants that appear in the program's instructions
	localparam logic [31:0] val_a = 32'd7;
	localparam logic [15:0] imm_b = 16'hfffd;
	localparam logic [15:0] imm_addi = 16'hfff6;
	localparam logic [15:0] imm_sltiu = 16'hffff;
	localparam logic [15:0] lui_imm = 16'h8765;
	localparam logic [15:0] ori_imm = 16'h9abc;
	localparam logic [15:0] andi_imm = 16'hf0f0;

	logic clk;
	logic rst;
	logic [31:0] pc;
	dbus_t dbus;

	logic [31:0] exp_addr [n_stores];
	logic [31:0] exp_data [n_stores];
	int store_count;
	int store_errors = 0;
	int reset_errors = 0;
	int end_errors = 0;

	mips_system UUT (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.dbus(dbus)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] sign_extend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic expect_store(input int idx, input logic [31:0] value);
		exp_addr[idx] = store_base + 32'(idx) * 32'd4; // Stores go to consecutive words
		exp_data[idx] = value;
	endtask

	task automatic fill_expected();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] upper;
		a = val_a;
		b = sign_extend(imm_b);
		upper = {lui_imm, 16'd0} | {16'd0, ori_imm}; // ori takes its immediate zero extended
		expect_store(0, a + b);
		expect_store(1, a - b);
		expect_store(2, a & b);
		expect_store(3, a | b);
		expect_store(4, a ^ b);
		expect_store(5, ~(a | b));
		expect_store(6, {31'd0, $signed(b) < $signed(a)});
		expect_store(7, {31'd0, b < a});
		expect_store(8, {31'd0, $signed(b) < 0});
		expect_store(9, {31'd0, a < sign_extend(imm_sltiu)});
		expect_store(10, a + sign_extend(imm_addi));
		expect_store(11, upper);
		expect_store(12, upper & {16'd0, andi_imm});
		expect_store(13, a << 4);
		expect_store(14, b >> 28);
		expect_store(15, $signed(b) >>> 1);
		expect_store(16, upper); // Read back with lw from store 11
		expect_store(17, a); // The store skipped by beq never shows up
		expect_store(18, jal_addr + 32'd4);
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic hold_reset();
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			store_count <= 0;
		end else if (dbus.write) begin
			store_count <= store_count + 1;
		end
	end

	reset_holds_bus: assert property (@(posedge clk) rst |-> !dbus.write)
		else begin
			$display("CHECK FAILED at %0t: data bus write while in reset", $time);
			reset_errors++;
		end

	pc_starts_at_zero: assert property (@(posedge clk) $fell(rst) |-> pc == 32'd0)
		else begin
			$display("CHECK FAILED at %0t: pc is %h after reset", $time, $sampled(pc));
			reset_errors++;
		end

	store_matches: assert property (@(posedge clk) disable iff (rst)
		dbus.write |-> store_count < n_stores
			&& dbus.addr == exp_addr[store_count]
			&& dbus.wdata == exp_data[store_count])
		else begin
			$display("CHECK FAILED at %0t: store %0d wrote %h to %h", $time,
				$sampled(store_count), $sampled(dbus.wdata), $sampled(dbus.addr));
			store_errors++;
		end

	initial begin
		logic [31:0] last_pc;
		clk = 1'b0;
		rst = 1'b1;
		fill_expected();
		hold_reset();
		while (pc != first_store_pc) begin
			wait_cycle();
		end
		hold_reset(); // Reset lands while a sw is on the bus, then the program reruns
		last_pc = 32'hffff_ffff;
		while (pc != last_pc) begin // The final self-jump holds pc still
			last_pc = pc;
			wait_cycle();
		end
		all_stores_seen: assert (store_count == n_stores)
			else begin
				$display("CHECK FAILED at %0t: %0d stores seen, %0d expected", $time,
					store_count, n_stores);
				end_errors++;
			end
		$display("Errors: %0d store, %0d reset, %0d end of program", store_errors,
			reset_errors, end_errors);
		if (store_errors + reset_errors + end_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(max_cycles * clk_period);
		$display("Timeout after %0d cycles: the program never reached its final loop",
			max_cycles);
		$display("Regression failed");
		$finish;
	end
endmodule

// ==== all.f ====
verilog/mips_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/instr_decoder.sv
verilog/cpu.sv
verilog/mips_system.sv
tb/mips_system_tb.sv

// ==== Makefile ====
TOP = mips_system_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f all.f -o sim

run: compile
	./obj_dir/sim > run.log 2>&1 || true
	cat run.log
	grep -q "^Regression passed$$" run.log

clean:
	rm -rf obj_dir run.log

// ==== tb/program.hex ====
// One 32-bit instruction word per line, in hex, starting at address 0.
// The trailing text gives the word address and the instruction.
24010007 // 00 addiu $1, $0, 7
2402fffd // 04 addiu $2, $0, -3
24100100 // 08 addiu $16, $0, 0x100
00221820 // 0c add $3, $1, $2
ae030000 // 10 sw $3, 0($16)
00222022 // 14 sub $4, $1, $2
ae040004 // 18 sw $4, 4($16)
00222824 // 1c and $5, $1, $2
ae050008 // 20 sw $5, 8($16)
00223025 // 24 or $6, $1, $2
ae06000c // 28 sw $6, 12($16)
00223826 // 2c xor $7, $1, $2
ae070010 // 30 sw $7, 16($16)
00224027 // 34 nor $8, $1, $2
ae080014 // 38 sw $8, 20($16)
0041482a // 3c slt $9, $2, $1
ae090018 // 40 sw $9, 24($16)
0041502b // 44 sltu $10, $2, $1
ae0a001c // 48 sw $10, 28($16)
284b0000 // 4c slti $11, $2, 0
ae0b0020 // 50 sw $11, 32($16)
2c2cffff // 54 sltiu $12, $1, -1
ae0c0024 // 58 sw $12, 36($16)
202dfff6 // 5c addi $13, $1, -10
ae0d0028 // 60 sw $13, 40($16)
3c0e8765 // 64 lui $14, 0x8765
35ce9abc // 68 ori $14, $14, 0x9abc
ae0e002c // 6c sw $14, 44($16)
31cff0f0 // 70 andi $15, $14, 0xf0f0
ae0f0030 // 74 sw $15, 48($16)
00018900 // 78 sll $17, $1, 4
ae110034 // 7c sw $17, 52($16)
00029702 // 80 srl $18, $2, 28
ae120038 // 84 sw $18, 56($16)
00029843 // 88 sra $19, $2, 1
ae13003c // 8c sw $19, 60($16)
8e14002c // 90 lw $20, 44($16)
ae140040 // 94 sw $20, 64($16)
10210002 // 98 beq $1, $1, 0xa0
ae000044 // 9c sw $0, 68($16)
14210002 // a0 bne $1, $1, 0xa8
ae010044 // a4 sw $1, 68($16)
0c00002d // a8 jal 0xb4
ae1f0048 // ac sw $31, 72($16)
0800002c // b0 j 0xb0
03e00008 // b4 jr $31
